/* hw/jtag_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width, opcode and constant macros for the JTAG TAP controller.
// Include in any file that sizes a register or decodes an opcode.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef JTAG_DEFS_SVH
`define JTAG_DEFS_SVH

// Instruction register
`define JTAG_IR_WIDTH        5
`define JTAG_IR_CAPTURE      5'b00101   // Fixed capture pattern, 01 in the LSBs

// Device identification
`define JTAG_IDCODE_WIDTH    32
`define JTAG_IDCODE_DEFAULT  32'h10000db3  // Version 1, part 0, manufacturer 0x6d9

// Opcodes
`define JTAG_OP_IDCODE       5'b00010
`define JTAG_OP_AXI_IN       5'b00100
`define JTAG_OP_AXI_OUT      5'b01000
`define JTAG_OP_BYPASS       5'b11111   // All ones, required by 1149.1

// Any opcode not listed above behaves as BYPASS

`endif

/* hw/jtag_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the TAP blocks: state encoding, active instruction and
// the decoded control flags that the state machine hands to the datapath.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "jtag_defs.svh"

package jtag_pkg;

    // IEEE 1149.1 TAP states
    typedef enum logic [3:0] {
        test_logic_reset,
        run_test_idle,
        select_dr_scan,
        capture_dr,
        shift_dr,
        exit1_dr,
        pause_dr,
        exit2_dr,
        update_dr,
        select_ir_scan,
        capture_ir,
        shift_ir,
        exit1_ir,
        pause_ir,
        exit2_ir,
        update_ir
    } tap_state_e;

    // Active instruction, value is the opcode
    typedef enum logic [`JTAG_IR_WIDTH-1:0] {
        INSTR_IDCODE  = `JTAG_OP_IDCODE,
        INSTR_AXI_IN  = `JTAG_OP_AXI_IN,
        INSTR_AXI_OUT = `JTAG_OP_AXI_OUT,
        INSTR_BYPASS  = `JTAG_OP_BYPASS
    } jtag_instr_e;

    // Per-state flags decoded from the FSM
    typedef struct packed {
        logic tlr;         // Test-Logic-Reset
        logic capture_dr;
        logic shift_dr;
        logic exit1_dr;
        logic update_dr;
        logic dr_path;     // Anywhere from Capture-DR to Update-DR
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
    } tap_ctrl_t;

endpackage

`default_nettype wire

/* hw/jtag_tap_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16-state TAP controller. Walks the 1149.1 state graph on TMS and hands
// the rest of the TAP a set of decoded flags instead of the raw state.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module jtag_tap_fsm (
    input  wire logic               tck_i,
    input  wire logic               rst_ni,     // TRST, async
    input  wire logic               tms_i,
    output jtag_pkg::tap_ctrl_t     tap_ctrl_o
);

    import jtag_pkg::*;

    tap_state_e state_q;
    tap_state_e state_d;

    // Next state, straight from the standard graph
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            test_logic_reset: state_d = tms_i ? test_logic_reset : run_test_idle;
            run_test_idle:    state_d = tms_i ? select_dr_scan   : run_test_idle;
            select_dr_scan:   state_d = tms_i ? select_ir_scan   : capture_dr;
            capture_dr:       state_d = tms_i ? exit1_dr         : shift_dr;
            shift_dr:         state_d = tms_i ? exit1_dr         : shift_dr;
            exit1_dr:         state_d = tms_i ? update_dr        : pause_dr;
            pause_dr:         state_d = tms_i ? exit2_dr         : pause_dr;
            exit2_dr:         state_d = tms_i ? update_dr        : shift_dr;
            update_dr:        state_d = tms_i ? select_dr_scan   : run_test_idle;
            select_ir_scan:   state_d = tms_i ? test_logic_reset : capture_ir;  // Last TMS=1 step
            capture_ir:       state_d = tms_i ? exit1_ir         : shift_ir;
            shift_ir:         state_d = tms_i ? exit1_ir         : shift_ir;
            exit1_ir:         state_d = tms_i ? update_ir        : pause_ir;
            pause_ir:         state_d = tms_i ? exit2_ir         : pause_ir;
            exit2_ir:         state_d = tms_i ? update_ir        : shift_ir;
            update_ir:        state_d = tms_i ? select_dr_scan   : run_test_idle;
        endcase
    end

    // Five TMS-high clocks land in Test-Logic-Reset from any state,
    // so no separate TMS history is kept
    always_ff @(posedge tck_i or negedge rst_ni)
    begin
        if (!rst_ni)
            state_q <= test_logic_reset;
        else
            state_q <= state_d;
    end

    // Flag decode, purely combinational on the current state
    always_comb
    begin
        tap_ctrl_o            = '0;
        tap_ctrl_o.tlr        = (state_q == test_logic_reset);
        tap_ctrl_o.capture_dr = (state_q == capture_dr);
        tap_ctrl_o.shift_dr   = (state_q == shift_dr);
        tap_ctrl_o.exit1_dr   = (state_q == exit1_dr);
        tap_ctrl_o.update_dr  = (state_q == update_dr);
        tap_ctrl_o.capture_ir = (state_q == capture_ir);
        tap_ctrl_o.shift_ir   = (state_q == shift_ir);
        tap_ctrl_o.update_ir  = (state_q == update_ir);

        // DR column below Select-DR-Scan
        case (state_q)
            capture_dr,
            shift_dr,
            exit1_dr,
            pause_dr,
            exit2_dr,
            update_dr: tap_ctrl_o.dr_path = 1'b1;
            default:   tap_ctrl_o.dr_path = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/jtag_ir.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction register. Captures a fixed pattern, shifts LSB out first and
// latches the opcode in Update-IR; the latched opcode becomes the active
// instruction seen by the data registers and the TDO stage.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "jtag_defs.svh"

module jtag_ir (
    input  wire logic               tck_i,
    input  wire logic               rst_ni,
    input  wire logic               td_i,
    input  jtag_pkg::tap_ctrl_t     tap_ctrl_i,
    output logic                    ir_tdo_o,
    output jtag_pkg::jtag_instr_e   instr_o
);

    import jtag_pkg::*;

    logic [`JTAG_IR_WIDTH-1:0] ir_q;       // Shift stage
    logic [`JTAG_IR_WIDTH-1:0] opcode_q;   // Latched in Update-IR

    // Shift stage, TDI enters at the MSB
    always_ff @(posedge tck_i or negedge rst_ni)
    begin
        if (!rst_ni)
            ir_q <= '0;
        else if (tap_ctrl_i.capture_ir)
            ir_q <= `JTAG_IR_CAPTURE;                        // Known pattern for chain check
        else if (tap_ctrl_i.shift_ir)
            ir_q <= {td_i, ir_q[`JTAG_IR_WIDTH-1:1]};
    end

    assign ir_tdo_o = ir_q[0];

    // Active opcode
    always_ff @(posedge tck_i or negedge rst_ni)
    begin
        if (!rst_ni)
            opcode_q <= `JTAG_OP_IDCODE;                     // IDCODE out of reset
        else if (tap_ctrl_i.tlr)
            opcode_q <= `JTAG_OP_IDCODE;                     // And again in Test-Logic-Reset
        else if (tap_ctrl_i.update_ir)
            opcode_q <= ir_q;
    end

    // Opcode to instruction, unknown codes fall back to bypass
    always_comb
    begin
        case (opcode_q)
            `JTAG_OP_IDCODE:  instr_o = INSTR_IDCODE;
            `JTAG_OP_AXI_IN:  instr_o = INSTR_AXI_IN;
            `JTAG_OP_AXI_OUT: instr_o = INSTR_AXI_OUT;
            default:          instr_o = INSTR_BYPASS;
        endcase
    end

endmodule

`default_nettype wire

/* hw/jtag_data_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data register side of the TAP: internal IDCODE and BYPASS registers,
// select and clear-to-access strobes for the two external AXI registers,
// and the scan-out mux feeding the TDO stage.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "jtag_defs.svh"

module jtag_data_regs #(
    parameter logic [`JTAG_IDCODE_WIDTH-1:0] IDCODE_VALUE = `JTAG_IDCODE_DEFAULT
) (
    input  wire logic               tck_i,
    input  wire logic               rst_ni,
    input  wire logic               td_i,
    input  jtag_pkg::tap_ctrl_t     tap_ctrl_i,
    input  jtag_pkg::jtag_instr_e   instr_i,
    input  wire logic               axi_data_in_tdo_i,    // Scan out of data-in register
    input  wire logic               axi_data_out_tdo_i,   // Scan out of data-out register
    output logic                    axi_data_in_sel_o,
    output logic                    axi_data_out_sel_o,
    output logic                    axi_in_cta_o,
    output logic                    axi_out_cta_o,
    output logic                    dr_tdo_o
);

    import jtag_pkg::*;

    logic [`JTAG_IDCODE_WIDTH-1:0] idcode_q;
    logic                          bypass_q;
    logic                          idcode_sel;

    assign idcode_sel = (instr_i == INSTR_IDCODE);

    // IDCODE, reloaded on capture and on Exit1 so a partial read restarts clean
    always_ff @(posedge tck_i or negedge rst_ni)
    begin
        if (!rst_ni)
            idcode_q <= IDCODE_VALUE;
        else if (idcode_sel && tap_ctrl_i.shift_dr)
            idcode_q <= {td_i, idcode_q[`JTAG_IDCODE_WIDTH-1:1]};
        else if (idcode_sel && (tap_ctrl_i.capture_dr || tap_ctrl_i.exit1_dr))
            idcode_q <= IDCODE_VALUE;
    end

    // Single-bit bypass, loads in every Shift-DR
    always_ff @(posedge tck_i or negedge rst_ni)
    begin
        if (!rst_ni)
            bypass_q <= 1'b0;
        else if (tap_ctrl_i.shift_dr)
            bypass_q <= td_i;
    end

    // External register selects
    assign axi_data_in_sel_o  = (instr_i == INSTR_AXI_IN);
    assign axi_data_out_sel_o = (instr_i == INSTR_AXI_OUT);

    // Clear to access, low while JTAG owns the register in the DR column
    assign axi_in_cta_o  = !(axi_data_in_sel_o  && tap_ctrl_i.dr_path);
    assign axi_out_cta_o = !(axi_data_out_sel_o && tap_ctrl_i.dr_path);

    // Scan-out mux by instruction
    always_comb
    begin
        case (instr_i)
            INSTR_IDCODE:  dr_tdo_o = idcode_q[0];
            INSTR_AXI_IN:  dr_tdo_o = axi_data_in_tdo_i;
            INSTR_AXI_OUT: dr_tdo_o = axi_data_out_tdo_i;
            default:       dr_tdo_o = bypass_q;      // INSTR_BYPASS
        endcase
    end

endmodule

`default_nettype wire

/* hw/jtag_tdo_out.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TDO output stage. Samples the IR and DR scan paths on the falling edge
// so TDO is settled half a cycle before the probe samples it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module jtag_tdo_out (
    input  wire logic               tck_i,
    input  jtag_pkg::tap_ctrl_t     tap_ctrl_i,
    input  jtag_pkg::jtag_instr_e   instr_i,
    input  wire logic               ir_tdo_i,
    input  wire logic               dr_tdo_i,
    output logic                    td_o
);

    import jtag_pkg::*;

    logic        shift_ir_q;   // Path flag as seen at the last falling edge
    jtag_instr_e instr_q;
    logic        ir_bit_q;
    logic        dr_bit_q;

    // All falling-edge samples, taken together
    always_ff @(negedge tck_i)
    begin
        shift_ir_q <= tap_ctrl_i.shift_ir;
        instr_q    <= instr_i;
        ir_bit_q   <= ir_tdo_i;
        if (instr_i == instr_q)
            dr_bit_q <= dr_tdo_i;     // Hold for the half cycle after an instruction change
    end

    // IR path only while in Shift-IR
    assign td_o = shift_ir_q ? ir_bit_q : dr_bit_q;

endmodule

`default_nettype wire

/* hw/jtag_tap_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// JTAG TAP top level. Connects the state machine, instruction register,
// data registers and TDO stage to the pins and to two external AXI scan
// registers. Set IDCODE_VALUE per device.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "jtag_defs.svh"

module jtag_tap_top #(
    parameter logic [`JTAG_IDCODE_WIDTH-1:0] IDCODE_VALUE = `JTAG_IDCODE_DEFAULT
) (
    // JTAG pins
    input  wire logic  tck_i,
    input  wire logic  rst_ni,               // TRST
    input  wire logic  tms_i,
    input  wire logic  td_i,
    output logic       td_o,
    // TAP state strobes for the external registers
    output logic       shift_dr_o,
    output logic       update_dr_o,
    output logic       capture_dr_o,
    output logic       scan_in_o,            // TDI towards the external registers
    // External AXI registers
    output logic       axi_data_in_sel_o,
    output logic       axi_data_out_sel_o,
    input  wire logic  axi_data_in_tdo_i,
    input  wire logic  axi_data_out_tdo_i,
    output logic       axi_in_cta_o,
    output logic       axi_out_cta_o
);

    import jtag_pkg::*;

    tap_ctrl_t   tap_ctrl;
    jtag_instr_e instr;
    logic        ir_tdo;
    logic        dr_tdo;

    assign scan_in_o    = td_i;
    assign shift_dr_o   = tap_ctrl.shift_dr;
    assign update_dr_o  = tap_ctrl.update_dr;
    assign capture_dr_o = tap_ctrl.capture_dr;

    jtag_tap_fsm i_jtag_tap_fsm (
        .tck_i      ( tck_i    ),
        .rst_ni     ( rst_ni   ),
        .tms_i      ( tms_i    ),
        .tap_ctrl_o ( tap_ctrl )
    );

    jtag_ir i_jtag_ir (
        .tck_i      ( tck_i    ),
        .rst_ni     ( rst_ni   ),
        .td_i       ( td_i     ),
        .tap_ctrl_i ( tap_ctrl ),
        .ir_tdo_o   ( ir_tdo   ),
        .instr_o    ( instr    )
    );

    jtag_data_regs #(
        .IDCODE_VALUE ( IDCODE_VALUE )
    ) i_jtag_data_regs (
        .tck_i              ( tck_i              ),
        .rst_ni             ( rst_ni             ),
        .td_i               ( td_i               ),
        .tap_ctrl_i         ( tap_ctrl           ),
        .instr_i            ( instr              ),
        .axi_data_in_tdo_i  ( axi_data_in_tdo_i  ),
        .axi_data_out_tdo_i ( axi_data_out_tdo_i ),
        .axi_data_in_sel_o  ( axi_data_in_sel_o  ),
        .axi_data_out_sel_o ( axi_data_out_sel_o ),
        .axi_in_cta_o       ( axi_in_cta_o       ),
        .axi_out_cta_o      ( axi_out_cta_o      ),
        .dr_tdo_o           ( dr_tdo             )
    );

    jtag_tdo_out i_jtag_tdo_out (
        .tck_i      ( tck_i    ),
        .tap_ctrl_i ( tap_ctrl ),
        .instr_i    ( instr    ),
        .ir_tdo_i   ( ir_tdo   ),
        .dr_tdo_i   ( dr_tdo   ),
        .td_o       ( td_o     )
    );

endmodule

`default_nettype wire

/* test/jtag_tap_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the TAP for the testbench. Tracks state, IR, IDCODE
// and BYPASS on every rising edge and compares the DUT pins against it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "jtag_defs.svh"

module jtag_tap_checker #(
    parameter logic [31:0] IDCODE_VALUE = `JTAG_IDCODE_DEFAULT
) (
    input  wire logic tck_i,
    input  wire logic rst_ni,
    input  wire logic tms_i,
    input  wire logic td_i,
    input  wire logic dut_tdo_i,
    input  wire logic dut_shift_dr_i,
    input  wire logic dut_update_dr_i,
    input  wire logic dut_capture_dr_i,
    input  wire logic dut_scan_in_i,
    input  wire logic dut_in_sel_i,
    input  wire logic dut_out_sel_i,
    input  wire logic dut_in_cta_i,
    input  wire logic dut_out_cta_i,
    input  wire logic axi_in_tdo_i,      // External model scan bits
    input  wire logic axi_out_tdo_i,
    input  wire logic [31:0] phase_i,
    output int        error_cnt_o,
    output int        check_cnt_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import jtag_pkg::*;

    tap_state_e  m_state;
    logic [4:0]  m_ir;
    logic [4:0]  m_opcode;
    logic [31:0] m_idcode;
    logic        m_bypass;
    int          tms_high;   // Consecutive TMS-high edges

    initial
    begin
        error_cnt_o = 0;
        check_cnt_o = 0;
        tms_high    = 0;
    end

    function automatic tap_state_e tap_next(tap_state_e s, logic tms);
        case (s)
            test_logic_reset: return tms ? test_logic_reset : run_test_idle;
            run_test_idle:    return tms ? select_dr_scan : run_test_idle;
            select_dr_scan:   return tms ? select_ir_scan : capture_dr;
            capture_dr:       return tms ? exit1_dr : shift_dr;
            shift_dr:         return tms ? exit1_dr : shift_dr;
            exit1_dr:         return tms ? update_dr : pause_dr;
            pause_dr:         return tms ? exit2_dr : pause_dr;
            exit2_dr:         return tms ? update_dr : shift_dr;
            update_dr:        return tms ? select_dr_scan : run_test_idle;
            select_ir_scan:   return tms ? test_logic_reset : capture_ir;
            capture_ir:       return tms ? exit1_ir : shift_ir;
            shift_ir:         return tms ? exit1_ir : shift_ir;
            exit1_ir:         return tms ? update_ir : pause_ir;
            pause_ir:         return tms ? exit2_ir : pause_ir;
            exit2_ir:         return tms ? update_ir : shift_ir;
            default:          return tms ? select_dr_scan : run_test_idle;
        endcase
    endfunction

    // Unknown opcodes act as bypass
    function automatic logic [4:0] effective_op(logic [4:0] op);
        if (op == `JTAG_OP_IDCODE || op == `JTAG_OP_AXI_IN || op == `JTAG_OP_AXI_OUT)
            return op;
        return `JTAG_OP_BYPASS;
    endfunction

    function automatic string phase_name(int p);
        case (p)
            1: return "idcode_read";
            2: return "ir_scan";
            3: return "bypass";
            4: return "axi_in";
            5: return "axi_out";
            6: return "random_walk";
            7: return "reset_mid_scan";
            8: return "random_run";
            default: return "reset";
        endcase
    endfunction

    task automatic compare(string sig, logic [31:0] exp, logic [31:0] act);
        check_cnt_o++;
        if (exp !== act)
        begin
            error_cnt_o++;
            $display("[FAIL] %s %s: expected %0h actual %0h", phase_name(phase_i), sig, exp, act);
        end
    endtask

    always @(posedge tck_i or negedge rst_ni)
    begin
        logic [4:0] op;
        logic       dr_path;
        if (!rst_ni)
        begin
            m_state  = test_logic_reset;
            m_ir     = '0;
            m_opcode = `JTAG_OP_IDCODE;
            m_idcode = IDCODE_VALUE;
            m_bypass = 1'b0;
            tms_high = 0;
        end
        else
        begin
            op      = effective_op(m_opcode);
            dr_path = (m_state >= capture_dr) && (m_state <= update_dr);   // DR column
            compare("capture_dr_o", m_state == capture_dr, dut_capture_dr_i);
            compare("shift_dr_o", m_state == shift_dr, dut_shift_dr_i);
            compare("update_dr_o", m_state == update_dr, dut_update_dr_i);
            compare("scan_in_o", td_i, dut_scan_in_i);
            compare("axi_data_in_sel_o", op == `JTAG_OP_AXI_IN, dut_in_sel_i);
            compare("axi_data_out_sel_o", op == `JTAG_OP_AXI_OUT, dut_out_sel_i);
            compare("axi_in_cta_o", !(op == `JTAG_OP_AXI_IN && dr_path), dut_in_cta_i);
            compare("axi_out_cta_o", !(op == `JTAG_OP_AXI_OUT && dr_path), dut_out_cta_i);

            // Five TMS-high edges end in Test-Logic-Reset and the next restores IDCODE
            if (tms_high >= 5)
                compare("five TMS high, DR strobes", 3'b000,
                        {dut_capture_dr_i, dut_shift_dr_i, dut_update_dr_i});
            if (tms_high >= 6)
                compare("five TMS high, selects and cta", 4'b0011,
                        {dut_in_sel_i, dut_out_sel_i, dut_in_cta_i, dut_out_cta_i});

            // TDO carries the LSB left by the previous shift
            if (m_state == shift_ir)
                compare("td_o (IR)", m_ir[0], dut_tdo_i);
            else if (m_state == shift_dr)
            begin
                case (op)
                    `JTAG_OP_IDCODE:  compare("td_o (IDCODE)", m_idcode[0], dut_tdo_i);
                    `JTAG_OP_AXI_IN:  compare("td_o (AXI in)", axi_in_tdo_i, dut_tdo_i);
                    `JTAG_OP_AXI_OUT: compare("td_o (AXI out)", axi_out_tdo_i, dut_tdo_i);
                    default:          compare("td_o (BYPASS)", m_bypass, dut_tdo_i);
                endcase
            end

            // Model update
            if (m_state == capture_ir)
                m_ir = `JTAG_IR_CAPTURE;
            else if (m_state == shift_ir)
                m_ir = {td_i, m_ir[4:1]};
            if (m_state == test_logic_reset)
                m_opcode = `JTAG_OP_IDCODE;
            else if (m_state == update_ir)
                m_opcode = m_ir;
            if (op == `JTAG_OP_IDCODE && m_state == shift_dr)
                m_idcode = {td_i, m_idcode[31:1]};
            else if (op == `JTAG_OP_IDCODE && (m_state == capture_dr || m_state == exit1_dr))
                m_idcode = IDCODE_VALUE;
            if (m_state == shift_dr)
                m_bypass = td_i;
            tms_high = tms_i ? tms_high + 1 : 0;
            m_state  = tap_next(m_state, tms_i);
        end
    end

endmodule

`default_nettype wire

/* test/tb_jtag_tap.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the JTAG TAP. Directed TMS sequences and a long random run,
// two 8-bit external scan registers, checker instance and timeout.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "jtag_defs.svh"

module tb_jtag_tap;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 4000;   // Phases take about 3600

    logic tck_i, rst_ni, tms_i, td_i;
    logic td_o, shift_dr, update_dr, capture_dr, scan_in;
    logic in_sel, out_sel, in_cta, out_cta;
    logic [7:0] ext_in_q  = 8'ha5;          // AXI data-in register model
    logic [7:0] ext_out_q = 8'h3c;          // AXI data-out register model
    int   phase;
    int   errors, checks;
    int   cycle_cnt;

    always #50 tck_i = ~tck_i;

    jtag_tap_top i_jtag_tap_top (
        .tck_i (tck_i), .rst_ni (rst_ni), .tms_i (tms_i), .td_i (td_i), .td_o (td_o),
        .shift_dr_o (shift_dr), .update_dr_o (update_dr), .capture_dr_o (capture_dr),
        .scan_in_o (scan_in),
        .axi_data_in_sel_o (in_sel), .axi_data_out_sel_o (out_sel),
        .axi_data_in_tdo_i (ext_in_q[0]), .axi_data_out_tdo_i (ext_out_q[0]),
        .axi_in_cta_o (in_cta), .axi_out_cta_o (out_cta)
    );

    jtag_tap_checker i_checker (
        .tck_i (tck_i), .rst_ni (rst_ni), .tms_i (tms_i), .td_i (td_i),
        .dut_tdo_i (td_o), .dut_shift_dr_i (shift_dr), .dut_update_dr_i (update_dr),
        .dut_capture_dr_i (capture_dr), .dut_scan_in_i (scan_in),
        .dut_in_sel_i (in_sel), .dut_out_sel_i (out_sel),
        .dut_in_cta_i (in_cta), .dut_out_cta_i (out_cta),
        .axi_in_tdo_i (ext_in_q[0]), .axi_out_tdo_i (ext_out_q[0]),
        .phase_i (phase), .error_cnt_o (errors), .check_cnt_o (checks)
    );

    // External scan registers, LSB out
    always @(posedge tck_i)
    begin
        if (in_sel && shift_dr)
            ext_in_q <= {scan_in, ext_in_q[7:1]};
        if (out_sel && shift_dr)
            ext_out_q <= {scan_in, ext_out_q[7:1]};
    end

    // Guard against a stuck run
    always @(posedge tck_i)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // One cycle of TMS/TDI, applied just after the rising edge
    task automatic drive(logic tms, logic tdi);
        @(posedge tck_i);
        #5;
        tms_i = tms;
        td_i  = tdi;
    endtask

    task automatic reset_tap();
        repeat (5) drive(1'b1, 1'($urandom));
        drive(1'b0, 1'b0);                   // Into Run-Test/Idle
    endtask

    // From Run-Test/Idle, back to it afterwards
    task automatic scan_ir(logic [63:0] bits, int n);
        drive(1'b1, 1'b0);
        drive(1'b1, 1'b0);
        drive(1'b0, 1'b0);
        drive(1'b0, 1'b0);
        for (int i = 0; i < n; i++)
            drive(i == n - 1, bits[i]);     // Last bit leaves via Exit1-IR
        drive(1'b1, 1'b0);
        drive(1'b0, 1'b0);
    endtask

    task automatic scan_dr(logic [63:0] bits, int n);
        drive(1'b1, 1'b0);
        drive(1'b0, 1'b0);
        drive(1'b0, 1'b0);
        for (int i = 0; i < n; i++)
            drive(i == n - 1, bits[i]);
        drive(1'b1, 1'b0);
        drive(1'b0, 1'b0);
    endtask

    initial
    begin
        tck_i = 1'b0;
        rst_ni = 1'b0;
        tms_i = 1'b1;
        td_i = 1'b0;
        phase = 0;
        cycle_cnt = 0;
        void'($urandom(32'h930d_e320));
        repeat (4) @(posedge tck_i);
        #5 rst_ni = 1'b1;

        phase = 1;
        drive(1'b0, 1'b0);
        scan_dr({$urandom, $urandom}, 32);
        phase = 2;
        scan_ir({$urandom, $urandom}, 12);
        reset_tap();
        phase = 3;
        scan_ir(`JTAG_OP_BYPASS, 5);
        scan_dr({$urandom, $urandom}, 40);
        scan_ir(5'b10110, 5);               // Undefined opcode
        scan_dr({$urandom, $urandom}, 40);
        phase = 4;
        scan_ir(`JTAG_OP_AXI_IN, 5);
        scan_dr({$urandom, $urandom}, 16);
        scan_dr({$urandom, $urandom}, 12);
        phase = 5;
        scan_ir(`JTAG_OP_AXI_OUT, 5);
        scan_dr({$urandom, $urandom}, 16);
        scan_dr({$urandom, $urandom}, 12);
        phase = 6;
        repeat (150) drive(1'($urandom), 1'($urandom));
        reset_tap();
        scan_dr({$urandom, $urandom}, 32);

        // Async reset in the middle of a DR shift
        phase = 7;
        scan_ir(`JTAG_OP_AXI_IN, 5);
        drive(1'b1, 1'b0);
        drive(1'b0, 1'b0);
        drive(1'b0, 1'b0);
        repeat (6) drive(1'b0, 1'($urandom));
        @(posedge tck_i);
        #5;
        rst_ni = 1'b0;
        tms_i  = 1'b0;
        repeat (2) @(posedge tck_i);
        #5 rst_ni = 1'b1;
        scan_dr({$urandom, $urandom}, 32);

        phase = 8;
        repeat (3000) drive(($urandom % 3) == 0, 1'($urandom));   // Biased towards shifts
        @(posedge tck_i);
        #1;

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/jtag_pkg.sv
hw/jtag_tap_fsm.sv
hw/jtag_ir.sv
hw/jtag_data_regs.sv
hw/jtag_tdo_out.sv
hw/jtag_tap_top.sv
test/jtag_tap_checker.sv
test/tb_jtag_tap.sv

/* Bender.yml */
package:
  name: jtag_tap

export_include_dirs:
  - hw

sources:
  - hw/jtag_pkg.sv
  - hw/jtag_tap_fsm.sv
  - hw/jtag_ir.sv
  - hw/jtag_data_regs.sv
  - hw/jtag_tdo_out.sv
  - hw/jtag_tap_top.sv
  - target: test
    files:
      - test/jtag_tap_checker.sv
      - test/tb_jtag_tap.sv
